//--- hdl/aib_pkg.sv
`default_nettype none

package aib_pkg;

    // ====================================================================
    // sideband frame and calibration timing
    // ====================================================================

    localparam int SR_MS_LEN      = 16;                       // bits per sideband frame
    localparam int SR_CNT_W       = $clog2(SR_MS_LEN);        // frame bit counter width
    localparam int DCC_CAL_CYCLES = 24;                       // cal_req rise to cal_done
    localparam int DCC_CNT_W      = $clog2(DCC_CAL_CYCLES);   // calibration counter width

    // ====================================================================
    // status words
    // ====================================================================

    // master status word, sent MSB first on the sideband line
    typedef struct packed {
        logic       config_done;       // master core configured
        logic       osc_transfer_en;   // oscillator clock forwarding on
        logic       tx_transfer_en;    // master tx path enabled
        logic       rx_transfer_en;    // master rx path enabled
        logic       rx_dll_lock;       // master rx dll locked
        logic       tx_dcc_cal_done;   // master tx duty cycle calibrated
        logic [9:0] spare;             // carried through untouched
    } ms_status_t;

    // follower side status, registered off the sequencer state
    typedef struct packed {
        logic osc_transfer_en;
        logic tx_dcc_cal_done;
        logic tx_transfer_en;
        logic rx_transfer_en;
        logic link_up;
    } sl_status_t;

    // ====================================================================
    // follower bring-up sequencer
    // ====================================================================

    typedef enum logic [2:0] {
        SM_IDLE    = 3'd0,   // waiting for both sides configured
        SM_OSC_EN  = 3'd1,   // oscillator transfer enabled
        SM_DCC_CAL = 3'd2,   // duty cycle calibration running
        SM_TX_EN   = 3'd3,   // tx enabled, waiting on master
        SM_LINK_UP = 3'd4    // both directions up
    } sm_state_e;

endpackage

`default_nettype wire

//--- hdl/aib_sr_ms.sv
`timescale 1ns/1ps
`default_nettype none

module aib_sr_ms (
    input  logic                osc_clk,           // free running oscillator clock
    input  logic                rst_n,
    input  aib_pkg::ms_status_t ms_data_fr_core,   // status word from near-side core
    output logic                sr_data,           // sideband serial data
    output logic                sr_load            // high on last bit of frame
);

    import aib_pkg::*;

    logic [SR_CNT_W-1:0]  bit_cnt;    // position within current frame
    logic [SR_MS_LEN-1:0] sh_q;       // outgoing frame, MSB on the line
    logic                 frame_start;
    logic                 load_next;

    assign frame_start = (bit_cnt == '0);
    assign load_next   = (bit_cnt == SR_CNT_W'(SR_MS_LEN - 1));   // last bit goes out next

    // ====================================================================
    // frame counter
    // ====================================================================

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (load_next) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ====================================================================
    // shifter and load strobe
    // ====================================================================

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_q <= '0;
        end else if (frame_start) begin
            sh_q <= ms_data_fr_core;                      // sample core word
        end else begin
            sh_q <= {sh_q[SR_MS_LEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            sr_load <= 1'b0;
        end else begin
            sr_load <= load_next;                         // lines up with the LSB
        end
    end

    assign sr_data = sh_q[SR_MS_LEN-1];

    // frames run back to back, so the strobe repeats at the frame length
    a_load_period : assert property (@(posedge osc_clk) disable iff (!rst_n)
        sr_load |-> ##SR_MS_LEN sr_load)
        else $error("sr_load did not repeat after SR_MS_LEN cycles");

    a_load_single : assert property (@(posedge osc_clk) disable iff (!rst_n)
        sr_load |=> !sr_load)
        else $error("sr_load held longer than one bit");

endmodule

`default_nettype wire

//--- hdl/aib_sr_sl.sv
`timescale 1ns/1ps
`default_nettype none

module aib_sr_sl (
    input  logic                osc_clk,
    input  logic                rst_n,
    input  logic                sr_data,           // sideband serial data
    input  logic                sr_load,           // frame boundary strobe
    output aib_pkg::ms_status_t ms_data_to_core,   // last complete frame
    output logic                frame_valid        // one cycle pulse per new frame
);

    import aib_pkg::*;

    logic [SR_MS_LEN-2:0] rx_sh;      // all but the final bit of a frame
    logic [SR_CNT_W-1:0]  bit_cnt;    // bits seen since last strobe
    logic                 synced;     // first strobe seen

    // ====================================================================
    // incoming shift register
    // ====================================================================

    always_ff @(posedge osc_clk) begin
        rx_sh <= {rx_sh[SR_MS_LEN-3:0], sr_data};
    end

    // ====================================================================
    // frame capture
    // ====================================================================

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_data_to_core <= '0;
            frame_valid     <= 1'b0;
        end else begin
            frame_valid <= sr_load;
            if (sr_load) begin
                ms_data_to_core <= {rx_sh, sr_data};      // LSB arrives with the strobe
            end
        end
    end

    // bit count between strobes, only meaningful once aligned
    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            synced  <= 1'b0;
        end else if (sr_load) begin
            bit_cnt <= '0;
            synced  <= 1'b1;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // the far-side serializer must close every frame at the full length
    a_frame_len : assert property (@(posedge osc_clk) disable iff (!rst_n)
        (sr_load && synced) |-> (bit_cnt == SR_CNT_W'(SR_MS_LEN - 1)))
        else $error("strobe closed a frame of %0d bits", bit_cnt + 1);

endmodule

`default_nettype wire

//--- hdl/aib_dcc.sv
`timescale 1ns/1ps
`default_nettype none

module aib_dcc (
    input  logic osc_clk,
    input  logic rst_n,
    input  logic cal_req,     // level request from sequencer
    output logic cal_done     // held until the request drops
);

    import aib_pkg::*;

    logic [DCC_CNT_W-1:0] cal_cnt;   // cycles since request rose

    // ====================================================================
    // calibration timer
    // ====================================================================

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            cal_cnt  <= '0;
            cal_done <= 1'b0;
        end else if (!cal_req) begin
            cal_cnt  <= '0;                               // restart on next request
            cal_done <= 1'b0;
        end else if (!cal_done) begin
            if (cal_cnt == DCC_CNT_W'(DCC_CAL_CYCLES - 1)) begin
                cal_done <= 1'b1;
            end else begin
                cal_cnt <= cal_cnt + 1'b1;
            end
        end
    end

    // done only after a request that stayed up for the whole calibration
    a_done_needs_req : assert property (@(posedge osc_clk) disable iff (!rst_n)
        $rose(cal_done) |-> cal_req && $past(cal_req, DCC_CAL_CYCLES - 1))
        else $error("cal_done rose without a full calibration request");

endmodule

`default_nettype wire

//--- hdl/aib_sm.sv
`timescale 1ns/1ps
`default_nettype none

module aib_sm (
    input  logic                osc_clk,
    input  logic                rst_n,
    input  logic                sl_config_done,   // follower core configured
    input  aib_pkg::ms_status_t ms_rx,            // last received master frame
    input  logic                frame_valid,      // new frame on ms_rx
    input  logic                cal_done,         // from duty cycle calibration
    output logic                cal_req,
    output aib_pkg::sl_status_t sl_status
);

    import aib_pkg::*;

    sm_state_e state_q;
    sm_state_e state_d;
    logic      abort;        // drop back to idle

    // config lost on either side
    assign abort = !sl_config_done || (frame_valid && !ms_rx.config_done);

    // ====================================================================
    // next state
    // ====================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            SM_IDLE: begin
                if (frame_valid && sl_config_done && ms_rx.config_done) begin
                    state_d = SM_OSC_EN;
                end
            end
            SM_OSC_EN: begin
                if (frame_valid && ms_rx.osc_transfer_en) begin
                    state_d = SM_DCC_CAL;
                end
            end
            SM_DCC_CAL: begin
                if (cal_done) begin                       // no frame needed here
                    state_d = SM_TX_EN;
                end
            end
            SM_TX_EN: begin
                if (frame_valid && ms_rx.tx_transfer_en && ms_rx.tx_dcc_cal_done) begin
                    state_d = SM_LINK_UP;
                end
            end
            SM_LINK_UP: begin
                state_d = SM_LINK_UP;
            end
            default: begin
                state_d = SM_IDLE;
            end
        endcase

        // loss of configuration wins over any forward step
        if (abort) begin
            state_d = SM_IDLE;
        end
    end

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign cal_req = (state_q == SM_DCC_CAL);   // level request for the whole wait

    // ====================================================================
    // status outputs
    // ====================================================================

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            sl_status <= '0;
        end else begin
            sl_status.osc_transfer_en <= (state_q != SM_IDLE);
            sl_status.tx_dcc_cal_done <= (state_q == SM_TX_EN) || (state_q == SM_LINK_UP);
            sl_status.tx_transfer_en  <= (state_q == SM_TX_EN) || (state_q == SM_LINK_UP);
            sl_status.rx_transfer_en  <= (state_q == SM_LINK_UP);
            sl_status.link_up         <= (state_q == SM_LINK_UP);
        end
    end

    // link comes up only after tx was already enabled for at least a cycle
    a_link_after_tx : assert property (@(posedge osc_clk) disable iff (!rst_n)
        $rose(sl_status.link_up) |-> sl_status.tx_transfer_en
                                     && $past(sl_status.tx_transfer_en))
        else $error("link_up without prior tx_transfer_en");

endmodule

`default_nettype wire

//--- hdl/aib_sideband_top.sv
`timescale 1ns/1ps
`default_nettype none

module aib_sideband_top (
    input  logic                osc_clk,          // free running oscillator clock
    input  logic                rst_n,
    input  aib_pkg::ms_status_t ms_core,          // master status from near-side core
    input  logic                sl_config_done,
    output aib_pkg::ms_status_t ms_rx,            // rebuilt master status
    output logic                frame_valid,
    output logic                sr_data,          // sideband line, for observation
    output logic                sr_load,
    output aib_pkg::sl_status_t sl_status
);

    logic cal_req;
    logic cal_done;

    // ====================================================================
    // sideband serial link
    // ====================================================================

    aib_sr_ms aib_sr_ms (
        .osc_clk         (osc_clk),
        .rst_n           (rst_n),
        .ms_data_fr_core (ms_core),
        .sr_data         (sr_data),       // master serial data out
        .sr_load         (sr_load)        // master load out
    );

    aib_sr_sl aib_sr_sl (
        .osc_clk         (osc_clk),
        .rst_n           (rst_n),
        .sr_data         (sr_data),
        .sr_load         (sr_load),
        .ms_data_to_core (ms_rx),
        .frame_valid     (frame_valid)
    );

    // ====================================================================
    // follower bring-up
    // ====================================================================

    aib_dcc aib_dcc (
        .osc_clk  (osc_clk),
        .rst_n    (rst_n),
        .cal_req  (cal_req),
        .cal_done (cal_done)
    );

    aib_sm aib_sm (
        .osc_clk        (osc_clk),
        .rst_n          (rst_n),
        .sl_config_done (sl_config_done),
        .ms_rx          (ms_rx),
        .frame_valid    (frame_valid),
        .cal_done       (cal_done),
        .cal_req        (cal_req),
        .sl_status      (sl_status)
    );

endmodule

`default_nettype wire

//--- sim/aib_sb_model.svh
`ifndef AIB_SB_MODEL_SVH
`define AIB_SB_MODEL_SVH

// ====================================================================
// reference model advanced once per rising edge after reset release
// ====================================================================

int                   m_edge;            // index of the next edge since reset release
ms_status_t           m_sent_q[$];       // words sampled at frame start in arrival order
ms_status_t           m_rx;
logic                 m_load;
logic                 m_fv;
logic [SR_MS_LEN-1:0] m_line;            // word being shifted onto the line
logic                 m_sr_data;
sm_state_e            m_state;
int                   m_cal_cnt;         // cycles the calibration request has been up
logic                 m_cal_done;
sl_status_t           m_sl;
int                   m_cal_enter;       // edge at which the calibration wait began

// status bits as a function of the sequencer state
function automatic sl_status_t status_of(input sm_state_e s);
    sl_status_t st;
    st = '0;
    st.osc_transfer_en = (s != SM_IDLE);
    st.tx_dcc_cal_done = (s == SM_TX_EN) || (s == SM_LINK_UP);
    st.tx_transfer_en  = (s == SM_TX_EN) || (s == SM_LINK_UP);
    st.rx_transfer_en  = (s == SM_LINK_UP);
    st.link_up         = (s == SM_LINK_UP);
    return st;
endfunction

function automatic void reset_model();
    m_edge      = 0;
    m_sent_q.delete();
    m_rx        = '0;
    m_load      = 1'b0;
    m_fv        = 1'b0;
    m_line      = '0;
    m_sr_data   = 1'b0;
    m_state     = SM_IDLE;
    m_cal_cnt   = 0;
    m_cal_done  = 1'b0;
    m_sl        = '0;
    m_cal_enter = 0;
endfunction

// all decisions use the values that were present before this edge
function automatic void advance_model();
    sm_state_e nxt;
    logic      drop;
    drop = !sl_config_done || (m_fv && !m_rx.config_done);
    nxt  = m_state;
    case (m_state)
        SM_IDLE:    if (m_fv && sl_config_done && m_rx.config_done) nxt = SM_OSC_EN;
        SM_OSC_EN:  if (m_fv && m_rx.osc_transfer_en) nxt = SM_DCC_CAL;
        SM_DCC_CAL: if (m_cal_done) nxt = SM_TX_EN;
        SM_TX_EN:   if (m_fv && m_rx.tx_transfer_en && m_rx.tx_dcc_cal_done) nxt = SM_LINK_UP;
        default:    nxt = m_state;
    endcase
    if (drop) begin
        nxt = SM_IDLE;
    end

    if (m_state == SM_DCC_CAL) begin                       // request held through this cycle
        if (m_cal_cnt < DCC_CAL_CYCLES) m_cal_cnt++;
        m_cal_done = (m_cal_cnt == DCC_CAL_CYCLES);
    end else begin
        m_cal_cnt  = 0;
        m_cal_done = 1'b0;
    end
    m_sl = status_of(m_state);

    // frame delivered one full frame after its start sample
    m_fv = (m_edge >= SR_MS_LEN) && (m_edge % SR_MS_LEN == 0);
    if (m_fv && m_sent_q.size() > 0) m_rx = m_sent_q.pop_front();
    if (m_edge % SR_MS_LEN == 0) m_sent_q.push_back(ms_core);
    if (m_edge % SR_MS_LEN == 0) m_line = ms_core;         // serializer loads at frame start
    m_sr_data = m_line[SR_MS_LEN - 1 - m_edge % SR_MS_LEN];
    m_load = (m_edge % SR_MS_LEN == SR_MS_LEN - 1);        // strobe on the last bit

    if (nxt == SM_DCC_CAL && m_state != SM_DCC_CAL) m_cal_enter = m_edge;
    m_state = nxt;
    m_edge++;
endfunction

`endif

//--- sim/tb_aib_sideband.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aib_sideband;

    import aib_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int T2_WORDS      = 20;
    localparam int ABORT_ROUNDS  = 6;
    localparam int SPARE_FRAMES  = 8;
    // worst case frames of each test plus a margin of 20
    localparam int TOTAL_FRAMES  = 1 + T2_WORDS * 3 + 14 + (3 + ABORT_ROUNDS * 20 + 11)
                                   + SPARE_FRAMES + 20;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * SR_MS_LEN + RESET_CYCLES;

    localparam sl_status_t ST_OFF = 5'b0_0000;
    localparam sl_status_t ST_OSC = 5'b1_0000;
    localparam sl_status_t ST_TX  = 5'b1_1100;
    localparam sl_status_t ST_UP  = 5'b1_1111;

    logic       osc_clk;
    logic       rst_n;
    ms_status_t ms_core;
    logic       sl_config_done;
    ms_status_t ms_rx;
    logic       frame_valid;
    logic       sr_data;
    logic       sr_load;
    sl_status_t sl_status;

    ms_status_t drv_core;      // applied on the next drive point
    logic       drv_cfg;
    logic       spare_churn;   // new random spare bits every cycle
    int         test_errs;
    int         pass_cnt;
    int         fail_cnt;
    int         cal_wait;
    int         wd_cycles = 0;

    `include "aib_sb_model.svh"

    aib_sideband_top uut (
        .osc_clk        (osc_clk),
        .rst_n          (rst_n),
        .ms_core        (ms_core),
        .sl_config_done (sl_config_done),
        .ms_rx          (ms_rx),
        .frame_valid    (frame_valid),
        .sr_data        (sr_data),
        .sr_load        (sr_load),
        .sl_status      (sl_status)
    );

    initial begin
        osc_clk = 1'b0;
        forever #20 osc_clk = ~osc_clk;
    end

    always @(posedge osc_clk) begin
        wd_cycles++;
        if (wd_cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ====================================================================
    // compare tasks
    // ====================================================================

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ms_status(input string name, input ms_status_t exp,
                                   input ms_status_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_sl_status(input string name, input sl_status_t exp,
                                   input sl_status_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            test_errs++;
        end
    endtask

    // ====================================================================
    // cycle stepping
    // ====================================================================

    task automatic run_cycle();
        logic [31:0] r;
        @(posedge osc_clk);
        #1;
        advance_model();
        check_bit("sr_data", m_sr_data, sr_data);
        check_bit("sr_load", m_load, sr_load);
        check_bit("frame_valid", m_fv, frame_valid);
        check_ms_status("ms_rx", m_rx, ms_rx);
        check_sl_status("sl_status", m_sl, sl_status);
        #1;
        if (spare_churn) begin
            r = $urandom;
            drv_core.spare = r[9:0];
        end
        ms_core        = drv_core;
        sl_config_done = drv_cfg;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) run_cycle();
    endtask

    task automatic wait_status(input sl_status_t exp, input int max_frames, input string what);
        int waited;
        waited = 0;
        while (sl_status !== exp && waited < max_frames * SR_MS_LEN) begin
            run_cycle();
            waited++;
        end
        if (sl_status !== exp) begin
            $display("ERROR at %0t ns: %s not reached within %0d frames, model in %s",
                     $time, what, max_frames, m_state.name());
            test_errs++;
        end
    endtask

    // clear all master bits and let the frames in flight drain
    task automatic settle_idle(input int frames);
        drv_core       = '0;
        drv_cfg        = 1'b1;
        run_cycles(frames * SR_MS_LEN);
    endtask

    // stage 0 osc enabled, 1 calibration under way, 2 tx enabled, 3 link up
    task automatic bring_up(input int stage);
        drv_cfg              = 1'b1;
        drv_core.config_done = 1'b1;
        wait_status(ST_OSC, 3, "osc_transfer_en");
        if (stage >= 1) begin
            drv_core.osc_transfer_en = 1'b1;
            if (stage == 1) begin
                run_cycles(int'($urandom_range(20, 50)));
            end else begin
                wait_status(ST_TX, 5, "tx_transfer_en");
                cal_wait = m_edge - 1 - m_cal_enter;          // edge of first TX status
            end
        end
        if (stage >= 3) begin
            drv_core.tx_transfer_en  = 1'b1;
            drv_core.tx_dcc_cal_done = 1'b1;
            wait_status(ST_UP, 3, "link_up");
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", name, test_errs);
        end
        test_errs = 0;
    endtask

    // ====================================================================
    // test sequence
    // ====================================================================

    initial begin
        logic [31:0] r;
        int          hold;
        int          loads;
        int          n_frames;
        int          stage;
        void'($urandom(32'h9f73_f9b0));
        rst_n          = 1'b0;
        ms_core        = '0;
        sl_config_done = 1'b0;
        drv_core       = '0;
        drv_cfg        = 1'b0;
        spare_churn    = 1'b0;
        test_errs      = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        cal_wait       = -1;
        reset_model();
        repeat (RESET_CYCLES) @(posedge osc_clk);
        #2;
        rst_n = 1'b1;

        check_bit("frame_valid", 1'b0, frame_valid);
        check_bit("sr_load", 1'b0, sr_load);
        check_sl_status("sl_status", ST_OFF, sl_status);
        check_ms_status("ms_rx", '0, ms_rx);
        run_cycles(SR_MS_LEN);
        finish_test("1 reset values");

        loads    = 0;
        n_frames = 0;
        for (int w = 0; w < T2_WORDS; w++) begin
            r        = $urandom;
            drv_core = r[15:0];
            hold     = int'($urandom_range(1, 3));
            n_frames += hold;
            for (int c = 0; c < hold * SR_MS_LEN; c++) begin
                run_cycle();
                if (sr_load) loads++;
            end
        end
        check_count("sr_load strobes", n_frames, loads);
        finish_test("2 random frame delivery");

        spare_churn = 1'b1;
        settle_idle(3);
        bring_up(3);
        finish_test("3 full bring-up");
        check_count("calibration wait cycles", DCC_CAL_CYCLES + 2, cal_wait);
        finish_test("4 calibration timing");

        settle_idle(3);
        for (int i = 0; i < ABORT_ROUNDS; i++) begin
            stage = int'($urandom_range(0, 3));
            bring_up(stage);
            run_cycles(int'($urandom_range(0, 2 * SR_MS_LEN)));
            if ($urandom_range(0, 1) == 0) begin
                drv_core.config_done = 1'b0;                  // master side drops
            end else begin
                drv_cfg = 1'b0;                               // follower side drops
            end
            wait_status(ST_OFF, 3, "status cleared after config loss");
            settle_idle(3);
        end
        bring_up(3);
        finish_test("5 config loss and repeat");

        for (int c = 0; c < SPARE_FRAMES * SR_MS_LEN; c++) begin
            run_cycle();
            check_sl_status("sl_status", ST_UP, sl_status);
        end
        finish_test("6 spare bits");

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- aib_sideband_top.f
+incdir+sim
hdl/aib_pkg.sv
hdl/aib_sr_ms.sv
hdl/aib_sr_sl.sv
hdl/aib_dcc.sv
hdl/aib_sm.sv
hdl/aib_sideband_top.sv
sim/tb_aib_sideband.sv

//--- run_sim.sh
#!/bin/sh
# build the sideband testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_aib_sideband -Mdir "$OBJ" -o tb_aib_sideband \
        -f aib_sideband_top.f; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_aib_sideband" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "no pass line found in $LOG"
exit 1
